/* pkt_fifo.f */
+incdir+bench
common/pkt_fifo_pkg.sv
source/dual_port_ram.sv
source/gray_sync.sv
pkt_fifo/pkt_wr_ctrl.sv
pkt_fifo/pkt_rd_ctrl.sv
pkt_fifo/pkt_fifo_async.sv
bench/pkt_fifo_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = pkt_fifo_tb
FLIST     = pkt_fifo.f
BUILD     = obj_dir
PASS_MSG  = Done: no errors

.PHONY: sim clean

# build, run, and pass only when the testbench prints its pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

/* bench/pkt_table.svh */
// -------------------------------------------------------------------------
// packet stimulus table
// one row per packet, with its egress mode and the outcome it should get
// -------------------------------------------------------------------------

`ifndef PKT_TABLE_SVH
`define PKT_TABLE_SVH

// egress modes
localparam logic [1:0] MODE_FREE = 2'd0;
localparam logic [1:0] MODE_RAND = 2'd1;
localparam logic [1:0] MODE_HOLD = 2'd2;

// packet outcomes
localparam logic [1:0] OUT_KEEP = 2'd0;
localparam logic [1:0] OUT_ERR  = 2'd1;
localparam logic [1:0] OUT_OVFL = 2'd2;

typedef struct packed {
   logic [7:0]                       len;
   logic                             err;
   logic [1:0]                       mode;
   logic                             pause;
   logic [pkt_fifo_pkg::PTR_WID-1:0] thresh;
   logic [1:0]                       outcome;
} pkt_row_t;

localparam int N_ROWS = 20;

// columns: length, error, egress mode, pause before last, threshold, outcome
localparam pkt_row_t PKT_TABLE [N_ROWS] = '{
   '{8'd4,  1'b0, MODE_FREE, 1'b0, 6'd31, OUT_KEEP},
   '{8'd1,  1'b0, MODE_FREE, 1'b0, 6'd31, OUT_KEEP},
   '{8'd7,  1'b0, MODE_FREE, 1'b0, 6'd31, OUT_KEEP},
   '{8'd5,  1'b1, MODE_FREE, 1'b0, 6'd31, OUT_ERR},
   '{8'd3,  1'b0, MODE_FREE, 1'b0, 6'd31, OUT_KEEP},
   '{8'd6,  1'b0, MODE_FREE, 1'b1, 6'd31, OUT_KEEP},
   '{8'd9,  1'b0, MODE_RAND, 1'b0, 6'd31, OUT_KEEP},
   '{8'd12, 1'b0, MODE_RAND, 1'b0, 6'd31, OUT_KEEP},
   '{8'd2,  1'b1, MODE_RAND, 1'b0, 6'd31, OUT_ERR},
   '{8'd16, 1'b0, MODE_RAND, 1'b0, 6'd31, OUT_KEEP},
   // egress held off, words pile up until the FIFO is full
   '{8'd10, 1'b0, MODE_HOLD, 1'b0, 6'd5,  OUT_KEEP},
   '{8'd12, 1'b0, MODE_HOLD, 1'b0, 6'd25, OUT_KEEP},
   '{8'd8,  1'b0, MODE_HOLD, 1'b0, 6'd20, OUT_KEEP},
   '{8'd4,  1'b0, MODE_HOLD, 1'b0, 6'd30, OUT_OVFL},
   '{8'd2,  1'b1, MODE_HOLD, 1'b0, 6'd29, OUT_ERR},
   '{8'd2,  1'b0, MODE_HOLD, 1'b0, 6'd31, OUT_KEEP},
   '{8'd3,  1'b0, MODE_FREE, 1'b0, 6'd31, OUT_KEEP},
   '{8'd33, 1'b0, MODE_FREE, 1'b0, 6'd31, OUT_OVFL},
   '{8'd40, 1'b1, MODE_RAND, 1'b0, 6'd31, OUT_OVFL},
   '{8'd5,  1'b0, MODE_FREE, 1'b0, 6'd31, OUT_KEEP}
};

`endif

/* bench/pkt_fifo_tb.sv */
// -------------------------------------------------------------------------
// pkt_fifo_tb
// table-driven packets into the packet FIFO, a word queue model on the
// egress, drop pulse counts, flow control and stall checks
// -------------------------------------------------------------------------

`timescale 1ns/1ps

module pkt_fifo_tb;

   `include "pkt_table.svh"

   localparam int DEPTH = pkt_fifo_pkg::FIFO_DEPTH;
   localparam int NB    = pkt_fifo_pkg::DATA_BYTES;

   logic                                wr_clk = 1'b0;
   logic                                rd_clk = 1'b0;
   logic                                arst_n;
   logic                                in_valid;
   logic [pkt_fifo_pkg::DATA_WID-1:0]   in_data;
   logic [NB-1:0]                       in_keep;
   logic                                in_last;
   logic                                in_error;
   logic [pkt_fifo_pkg::PTR_WID-1:0]    flow_ctl_thresh;
   logic                                flow_ctl;
   logic                                ovfl_drop;
   logic                                err_drop;
   logic                                out_valid;
   logic                                out_ready = 1'b0;
   logic [pkt_fifo_pkg::DATA_WID-1:0]   out_data;
   logic [NB-1:0]                       out_keep;
   logic                                out_last;

   // reference model
   pkt_fifo_pkg::fifo_word_t            model_q [$];
   pkt_fifo_pkg::fifo_word_t            exp_word;
   logic [1:0]                          egress_mode = MODE_FREE;
   logic [31:0]                         word_cnt = '0;
   logic [31:0]                         prev_data = '0;
   logic                                ready_next;
   logic                                stall_prev = 1'b0;
   int held_words = 0;
   int exp_ovfl = 0;
   int exp_err = 0;
   int seen_ovfl = 0;
   int seen_err = 0;
   int data_errs = 0;
   int drop_errs = 0;
   int flow_errs = 0;
   int misc_errs = 0;
   int cycles = 0;

   always #10 wr_clk = ~wr_clk;
   always #13 rd_clk = ~rd_clk;

   pkt_fifo_async u_dut (
      .arst_n          (arst_n),
      .wr_clk          (wr_clk),
      .in_valid        (in_valid),
      .in_data         (in_data),
      .in_keep         (in_keep),
      .in_last         (in_last),
      .in_error        (in_error),
      .flow_ctl_thresh (flow_ctl_thresh),
      .flow_ctl        (flow_ctl),
      .ovfl_drop       (ovfl_drop),
      .err_drop        (err_drop),
      .rd_clk          (rd_clk),
      .out_valid       (out_valid),
      .out_ready       (out_ready),
      .out_data        (out_data),
      .out_keep        (out_keep),
      .out_last        (out_last)
   );

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] got);
      $display("Fail at %0t: %s expected %0h, got %0h", $time, name, exp, got);
   endtask

   task automatic print_counts();
      $display("errors: data %0d, drops %0d, flow %0d, other %0d",
               data_errs, drop_errs, flow_errs, misc_errs);
   endtask

   function automatic int total_len();
      int sum;
      sum = 0;
      for (int r = 0; r < N_ROWS; r++) begin
         sum += int'(PKT_TABLE[r].len);
      end
      return sum;
   endfunction

   // wait until every kept word has left, then let the read pointer settle
   task automatic drain();
      while (model_q.size() != 0) begin
         @(negedge wr_clk);
      end
      repeat (8) @(negedge wr_clk);
   endtask

   // -------------------------------------------------------------------------
   // runs one table row from a falling wr_clk edge
   // -------------------------------------------------------------------------
   task automatic run_row(input int idx, input pkt_row_t row);
      pkt_fifo_pkg::fifo_word_t w;
      logic [1:0]               predicted;
      logic                     fits;
      if (row.mode == MODE_HOLD) begin
         if (egress_mode != MODE_HOLD) begin
            drain();
            egress_mode = MODE_HOLD;
            held_words  = 0;
         end
      end else begin
         egress_mode = row.mode;
         drain();
      end
      flow_ctl_thresh = row.thresh;
      // free space is exact while held, the whole FIFO otherwise
      fits = (row.mode == MODE_HOLD) ? (held_words + int'(row.len) <= DEPTH)
                                     : (int'(row.len) <= DEPTH);
      predicted = !fits ? OUT_OVFL : (row.err ? OUT_ERR : OUT_KEEP);
      assert (predicted == row.outcome) else begin
         misc_errs++;
         $display("table row %0d lists outcome %0d, the rules give %0d",
                  idx, row.outcome, predicted);
      end
      for (int i = 0; i < int'(row.len); i++) begin
         if (row.pause && i == int'(row.len) - 1) begin
            in_valid = 1'b0;
            repeat (20) begin
               @(negedge wr_clk);
               assert (!out_valid) else begin
                  misc_errs++;
                  $display("out_valid rose at %0t before the last word", $time);
               end
            end
         end
         w.data   = word_cnt;
         w.last   = (i == int'(row.len) - 1);
         w.keep   = w.last ? NB'($urandom_range((1 << NB) - 1, 1)) : '1;
         in_valid = 1'b1;
         in_data  = w.data;
         in_keep  = w.keep;
         in_last  = w.last;
         // an error flag on an inner word must not affect the packet
         in_error = w.last ? row.err : 1'($urandom % 2);
         if (predicted == OUT_KEEP) begin
            model_q.push_back(w);
         end
         word_cnt++;
         @(negedge wr_clk);
      end
      in_valid = 1'b0;
      in_last  = 1'b0;
      in_error = 1'b0;
      if (predicted == OUT_KEEP && row.mode == MODE_HOLD) begin
         held_words += int'(row.len);
      end else if (predicted == OUT_OVFL) begin
         exp_ovfl++;
      end else if (predicted == OUT_ERR) begin
         exp_err++;
      end
      repeat (6) @(negedge wr_clk);
      assert (seen_ovfl == exp_ovfl) else begin
         drop_errs++;
         report_mismatch("ovfl_drop pulses", exp_ovfl, seen_ovfl);
      end
      assert (seen_err == exp_err) else begin
         drop_errs++;
         report_mismatch("err_drop pulses", exp_err, seen_err);
      end
      if (row.mode == MODE_HOLD) begin
         assert (flow_ctl == (held_words > int'(row.thresh))) else begin
            flow_errs++;
            report_mismatch("flow_ctl", held_words > int'(row.thresh), flow_ctl);
         end
      end
   endtask

   // -------------------------------------------------------------------------
   // drop pulse counters and egress monitor
   // -------------------------------------------------------------------------
   always @(negedge wr_clk) begin
      if (arst_n) begin
         if (ovfl_drop) begin
            seen_ovfl++;
         end
         if (err_drop) begin
            seen_err++;
         end
      end
   end

   always @(negedge rd_clk) begin
      if (!arst_n) begin
         out_ready  <= 1'b0;
         stall_prev = 1'b0;
      end else begin
         if (stall_prev) begin
            assert (out_valid) else begin
               misc_errs++;
               $display("out_valid fell at %0t while the word was stalled", $time);
            end
            assert (out_data == prev_data) else begin
               misc_errs++;
               report_mismatch("out_data while stalled", prev_data, out_data);
            end
         end
         case (egress_mode)
            MODE_FREE: ready_next = 1'b1;
            MODE_RAND: ready_next = 1'($urandom % 2);
            default:   ready_next = 1'b0;
         endcase
         out_ready <= ready_next;
         if (out_valid && ready_next) begin
            if (model_q.size() == 0) begin
               misc_errs++;
               $display("egress sent a word at %0t that no kept packet holds", $time);
            end else begin
               exp_word = model_q.pop_front();
               assert (out_data == exp_word.data) else begin
                  data_errs++;
                  report_mismatch("out_data", exp_word.data, out_data);
               end
               assert (out_keep == exp_word.keep) else begin
                  data_errs++;
                  report_mismatch("out_keep", 32'(exp_word.keep), 32'(out_keep));
               end
               assert (out_last == exp_word.last) else begin
                  data_errs++;
                  report_mismatch("out_last", 32'(exp_word.last), 32'(out_last));
               end
            end
         end
         stall_prev = out_valid && !ready_next;
         prev_data  = out_data;
      end
   end

   // -------------------------------------------------------------------------
   // main sequence and timeout
   // -------------------------------------------------------------------------
   initial begin
      void'($urandom(32'hd587_69ac));
      arst_n          = 1'b0;
      in_valid        = 1'b0;
      in_data         = '0;
      in_keep         = '0;
      in_last         = 1'b0;
      in_error        = 1'b0;
      flow_ctl_thresh = '0;
      repeat (2) @(negedge wr_clk);
      arst_n = 1'b1;
      repeat (6) @(negedge wr_clk);
      assert (!flow_ctl && !ovfl_drop && !err_drop && !out_valid) else begin
         misc_errs++;
         $display("outputs not idle after reset at %0t", $time);
      end
      for (int r = 0; r < N_ROWS; r++) begin
         run_row(r, PKT_TABLE[r]);
      end
      egress_mode = MODE_FREE;
      drain();
      print_counts();
      if (data_errs + drop_errs + flow_errs + misc_errs == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

   initial begin
      while (cycles < 40 * total_len() + 200) begin
         @(posedge wr_clk);
         cycles++;
      end
      $display("run timed out after %0d write clock cycles", cycles);
      print_counts();
      $display("Done: errors found");
      $finish;
   end

endmodule

/* pkt_fifo/pkt_fifo_async.sv */
// -------------------------------------------------------------------------
// pkt_fifo_async
// packet-aware asynchronous FIFO, store-and-forward between a write
// clock domain with always-accept ingress and a valid/ready egress
// -------------------------------------------------------------------------

`timescale 1ns/1ps

module pkt_fifo_async (
   input  logic                                  arst_n,

   // write domain
   input  logic                                  wr_clk,
   input  logic                                  in_valid,
   input  logic [pkt_fifo_pkg::DATA_WID-1:0]     in_data,
   input  logic [pkt_fifo_pkg::DATA_BYTES-1:0]   in_keep,
   input  logic                                  in_last,
   input  logic                                  in_error,
   input  logic [pkt_fifo_pkg::PTR_WID-1:0]      flow_ctl_thresh,
   output logic                                  flow_ctl,
   output logic                                  ovfl_drop,
   output logic                                  err_drop,

   // read domain
   input  logic                                  rd_clk,
   output logic                                  out_valid,
   input  logic                                  out_ready,
   output logic [pkt_fifo_pkg::DATA_WID-1:0]     out_data,
   output logic [pkt_fifo_pkg::DATA_BYTES-1:0]   out_keep,
   output logic                                  out_last
);

   // write domain
   logic                                 wr_arst_n;
   logic                                 wr_en;
   logic [pkt_fifo_pkg::ADDR_WID-1:0]    wr_addr;
   pkt_fifo_pkg::fifo_word_t             wr_word;
   logic [pkt_fifo_pkg::PTR_WID-1:0]     commit_ptr;
   logic [pkt_fifo_pkg::PTR_WID-1:0]     rd_ptr_wr;

   // read domain
   logic                                 rd_arst_n;
   logic [pkt_fifo_pkg::ADDR_WID-1:0]    rd_addr;
   pkt_fifo_pkg::fifo_word_t             rd_word;
   logic [pkt_fifo_pkg::PTR_WID-1:0]     rd_ptr;
   logic [pkt_fifo_pkg::PTR_WID-1:0]     commit_ptr_rd;

   // -------------------------------------------------------------------------
   // write side
   // -------------------------------------------------------------------------
   pkt_wr_ctrl u_wr_ctrl (
      .wr_clk          (wr_clk),
      .arst_n          (arst_n),
      .in_valid        (in_valid),
      .in_data         (in_data),
      .in_keep         (in_keep),
      .in_last         (in_last),
      .in_error        (in_error),
      .rd_ptr_wr       (rd_ptr_wr),
      .flow_ctl_thresh (flow_ctl_thresh),
      .wr_en           (wr_en),
      .wr_addr         (wr_addr),
      .wr_word         (wr_word),
      .commit_ptr      (commit_ptr),
      .wr_arst_n       (wr_arst_n),
      .flow_ctl        (flow_ctl),
      .ovfl_drop       (ovfl_drop),
      .err_drop        (err_drop)
   );

   dual_port_ram u_ram (
      .wr_clk  (wr_clk),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_word (wr_word),
      .rd_addr (rd_addr),
      .rd_word (rd_word)
   );

   // -------------------------------------------------------------------------
   // pointer crossings
   // -------------------------------------------------------------------------

   // committed pointer toward the reader
   gray_sync u_commit_sync (
      .src_clk    (wr_clk),
      .dst_clk    (rd_clk),
      .src_arst_n (wr_arst_n),
      .dst_arst_n (rd_arst_n),
      .src_ptr    (commit_ptr),
      .dst_ptr    (commit_ptr_rd)
   );

   // read pointer back to the writer for free space
   gray_sync u_rd_sync (
      .src_clk    (rd_clk),
      .dst_clk    (wr_clk),
      .src_arst_n (rd_arst_n),
      .dst_arst_n (wr_arst_n),
      .src_ptr    (rd_ptr),
      .dst_ptr    (rd_ptr_wr)
   );

   // -------------------------------------------------------------------------
   // read side
   // -------------------------------------------------------------------------
   pkt_rd_ctrl u_rd_ctrl (
      .rd_clk        (rd_clk),
      .arst_n        (arst_n),
      .commit_ptr_rd (commit_ptr_rd),
      .rd_word       (rd_word),
      .rd_addr       (rd_addr),
      .out_ready     (out_ready),
      .rd_ptr        (rd_ptr),
      .rd_arst_n     (rd_arst_n),
      .out_valid     (out_valid),
      .out_data      (out_data),
      .out_keep      (out_keep),
      .out_last      (out_last)
   );

endmodule

/* pkt_fifo/pkt_rd_ctrl.sv */
// -------------------------------------------------------------------------
// pkt_rd_ctrl
// read side of the packet FIFO: read pointer and valid/ready egress
// over committed words only
// -------------------------------------------------------------------------

`timescale 1ns/1ps

module pkt_rd_ctrl (
   input  logic                                  rd_clk,
   input  logic                                  arst_n,

   // committed write pointer as seen from this domain
   input  logic [pkt_fifo_pkg::PTR_WID-1:0]      commit_ptr_rd,

   // storage read port
   input  pkt_fifo_pkg::fifo_word_t              rd_word,
   output logic [pkt_fifo_pkg::ADDR_WID-1:0]     rd_addr,

   input  logic                                  out_ready,

   output logic [pkt_fifo_pkg::PTR_WID-1:0]      rd_ptr,
   output logic                                  rd_arst_n,

   // egress
   output logic                                  out_valid,
   output logic [pkt_fifo_pkg::DATA_WID-1:0]     out_data,
   output logic [pkt_fifo_pkg::DATA_BYTES-1:0]   out_keep,
   output logic                                  out_last
);

   logic [pkt_fifo_pkg::RST_STAGES-1:0] rst_sync;
   logic                                xfer;

   // -------------------------------------------------------------------------
   // reset synchronizer for the read domain
   // -------------------------------------------------------------------------
   always_ff @(posedge rd_clk or negedge arst_n) begin
      if (!arst_n) begin
         rst_sync <= '0;
      end else begin
         rst_sync <= {rst_sync[pkt_fifo_pkg::RST_STAGES-2:0], 1'b1};
      end
   end

   assign rd_arst_n = rst_sync[pkt_fifo_pkg::RST_STAGES-1];

   // -------------------------------------------------------------------------
   // egress
   // -------------------------------------------------------------------------

   // words up to the committed pointer belong to complete packets
   assign out_valid = (rd_ptr != commit_ptr_rd);
   assign xfer      = out_valid && out_ready;

   assign rd_addr  = rd_ptr[pkt_fifo_pkg::ADDR_WID-1:0];

   // fall-through, data follows the read address in the same cycle
   assign out_data = rd_word.data;
   assign out_keep = rd_word.keep;
   assign out_last = rd_word.last;

   // pointer holds while stalled, so the presented word stays put
   always_ff @(posedge rd_clk or negedge rd_arst_n) begin
      if (!rd_arst_n) begin
         rd_ptr <= '0;
      end else if (xfer) begin
         rd_ptr <= rd_ptr + 1'b1;
      end
   end

endmodule

/* pkt_fifo/pkt_wr_ctrl.sv */
// -------------------------------------------------------------------------
// pkt_wr_ctrl
// write side of the packet FIFO: speculative and committed pointers,
// whole-packet discard on overflow or error, drop pulses, flow control
// -------------------------------------------------------------------------

`timescale 1ns/1ps

module pkt_wr_ctrl (
   input  logic                                  wr_clk,
   input  logic                                  arst_n,

   // ingress, always accepted
   input  logic                                  in_valid,
   input  logic [pkt_fifo_pkg::DATA_WID-1:0]     in_data,
   input  logic [pkt_fifo_pkg::DATA_BYTES-1:0]   in_keep,
   input  logic                                  in_last,
   input  logic                                  in_error,

   // read pointer as seen from this domain
   input  logic [pkt_fifo_pkg::PTR_WID-1:0]      rd_ptr_wr,
   input  logic [pkt_fifo_pkg::PTR_WID-1:0]      flow_ctl_thresh,

   // storage write port
   output logic                                  wr_en,
   output logic [pkt_fifo_pkg::ADDR_WID-1:0]     wr_addr,
   output pkt_fifo_pkg::fifo_word_t              wr_word,

   output logic [pkt_fifo_pkg::PTR_WID-1:0]      commit_ptr,
   output logic                                  wr_arst_n,

   output logic                                  flow_ctl,
   output logic                                  ovfl_drop,
   output logic                                  err_drop
);

   logic [pkt_fifo_pkg::RST_STAGES-1:0] rst_sync;

   logic [pkt_fifo_pkg::PTR_WID-1:0]    wr_ptr;
   logic [pkt_fifo_pkg::PTR_WID-1:0]    wr_ptr_inc;
   logic [pkt_fifo_pkg::PTR_WID-1:0]    fill;
   logic                                full;
   logic                                dropping;
   logic                                lose_word;

   // -------------------------------------------------------------------------
   // reset synchronizer, asserts at once and releases on wr_clk
   // -------------------------------------------------------------------------
   always_ff @(posedge wr_clk or negedge arst_n) begin
      if (!arst_n) begin
         rst_sync <= '0;
      end else begin
         rst_sync <= {rst_sync[pkt_fifo_pkg::RST_STAGES-2:0], 1'b1};
      end
   end

   assign wr_arst_n = rst_sync[pkt_fifo_pkg::RST_STAGES-1];

   // -------------------------------------------------------------------------
   // occupancy and write port
   // -------------------------------------------------------------------------

   // counts speculative words too, so an open packet holds its space
   assign fill       = wr_ptr - rd_ptr_wr;
   assign full       = (fill == pkt_fifo_pkg::FULL_LVL);
   assign wr_ptr_inc = wr_ptr + 1'b1;

   // a word is lost when there is no room or the packet is already doomed
   assign lose_word  = in_valid && (dropping || full);

   assign wr_en        = in_valid && !dropping && !full;
   assign wr_addr      = wr_ptr[pkt_fifo_pkg::ADDR_WID-1:0];
   assign wr_word.data = in_data;
   assign wr_word.keep = in_keep;
   assign wr_word.last = in_last;

   // -------------------------------------------------------------------------
   // pointer control and drop reporting
   // -------------------------------------------------------------------------
   always_ff @(posedge wr_clk or negedge wr_arst_n) begin
      if (!wr_arst_n) begin
         wr_ptr     <= '0;
         commit_ptr <= '0;
         dropping   <= 1'b0;
         ovfl_drop  <= 1'b0;
         err_drop   <= 1'b0;
         flow_ctl   <= 1'b0;
      end else begin
         // drop outputs are single-cycle pulses
         ovfl_drop <= 1'b0;
         err_drop  <= 1'b0;
         flow_ctl  <= (fill > flow_ctl_thresh);

         if (in_valid) begin
            if (in_last) begin
               dropping <= 1'b0;
               if (lose_word) begin
                  // overflow wins over error
                  wr_ptr    <= commit_ptr;
                  ovfl_drop <= 1'b1;
               end else if (in_error) begin
                  wr_ptr   <= commit_ptr;
                  err_drop <= 1'b1;
               end else begin
                  // good packet becomes visible with its last word
                  wr_ptr     <= wr_ptr_inc;
                  commit_ptr <= wr_ptr_inc;
               end
            end else if (lose_word) begin
               dropping <= 1'b1;
            end else begin
               wr_ptr <= wr_ptr_inc;
            end
         end
      end
   end

endmodule

/* source/gray_sync.sv */
// -------------------------------------------------------------------------
// gray_sync
// moves a binary pointer into another clock domain as Gray code
// through a two-flop synchronizer, then decodes it back to binary
// -------------------------------------------------------------------------

`timescale 1ns/1ps

module gray_sync (
   input  logic                               src_clk,
   input  logic                               dst_clk,
   input  logic                               src_arst_n,
   input  logic                               dst_arst_n,
   input  logic [pkt_fifo_pkg::PTR_WID-1:0]   src_ptr,
   output logic [pkt_fifo_pkg::PTR_WID-1:0]   dst_ptr
);

   logic [pkt_fifo_pkg::PTR_WID-1:0] src_gray;
   logic [pkt_fifo_pkg::PTR_WID-1:0] meta_gray;
   logic [pkt_fifo_pkg::PTR_WID-1:0] dst_gray;

   // prefix xor from the msb down
   function automatic logic [pkt_fifo_pkg::PTR_WID-1:0] gray_to_bin(
      input logic [pkt_fifo_pkg::PTR_WID-1:0] g
   );
      logic [pkt_fifo_pkg::PTR_WID-1:0] b;
      b[pkt_fifo_pkg::PTR_WID-1] = g[pkt_fifo_pkg::PTR_WID-1];
      for (int i = pkt_fifo_pkg::PTR_WID - 2; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   // source side, registered so no combinational glitch reaches the crossing
   always_ff @(posedge src_clk or negedge src_arst_n) begin
      if (!src_arst_n) begin
         src_gray <= '0;
      end else begin
         src_gray <= src_ptr ^ (src_ptr >> 1);
      end
   end

   // destination side, two flops
   always_ff @(posedge dst_clk or negedge dst_arst_n) begin
      if (!dst_arst_n) begin
         meta_gray <= '0;
         dst_gray  <= '0;
      end else begin
         meta_gray <= src_gray;
         dst_gray  <= meta_gray;
      end
   end

   assign dst_ptr = gray_to_bin(dst_gray);

endmodule

/* source/dual_port_ram.sv */
// -------------------------------------------------------------------------
// dual_port_ram
// word storage with a clocked write port and an asynchronous read port
// -------------------------------------------------------------------------

`timescale 1ns/1ps

module dual_port_ram (
   input  logic                                 wr_clk,
   input  logic                                 wr_en,
   input  logic [pkt_fifo_pkg::ADDR_WID-1:0]    wr_addr,
   input  pkt_fifo_pkg::fifo_word_t             wr_word,
   input  logic [pkt_fifo_pkg::ADDR_WID-1:0]    rd_addr,
   output pkt_fifo_pkg::fifo_word_t             rd_word
);

   // storage array
   pkt_fifo_pkg::fifo_word_t mem [pkt_fifo_pkg::FIFO_DEPTH];

   // -------------------------------------------------------------------------
   // write port, owned by the write clock domain
   // -------------------------------------------------------------------------
   always_ff @(posedge wr_clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_word;
      end
   end

   // -------------------------------------------------------------------------
   // read port
   // -------------------------------------------------------------------------

   // combinational read gives first-word fall-through on the egress side.
   // the reader only addresses committed slots, which the writer leaves alone
   assign rd_word = mem[rd_addr];

endmodule

/* common/pkt_fifo_pkg.sv */
// -------------------------------------------------------------------------
// pkt_fifo shared definitions
// bus widths, storage depth, pointer widths and the stored word layout
// -------------------------------------------------------------------------

package pkt_fifo_pkg;

   // -------------------------------------------------------------------------
   // streaming bus
   // -------------------------------------------------------------------------

   // bytes carried per bus word
   localparam int DATA_BYTES = 4;

   localparam int DATA_WID   = DATA_BYTES * 8;

   // -------------------------------------------------------------------------
   // storage and pointers
   // -------------------------------------------------------------------------

   // number of stored words, must be a power of two
   localparam int FIFO_DEPTH = 32;

   localparam int ADDR_WID   = $clog2(FIFO_DEPTH);

   // one extra wrap bit tells full from empty
   localparam int PTR_WID    = ADDR_WID + 1;

   // pointer distance that means every slot is taken
   localparam logic [PTR_WID-1:0] FULL_LVL = PTR_WID'(FIFO_DEPTH);

   // flops in each reset synchronizer
   localparam int RST_STAGES = 2;

   // -------------------------------------------------------------------------
   // stored word
   // -------------------------------------------------------------------------

   // last flag on top, then byte keep mask, then data
   typedef struct packed {
      logic                  last;
      logic [DATA_BYTES-1:0] keep;
      logic [DATA_WID-1:0]   data;
   } fifo_word_t;

endpackage
